/* common/vision_pkg.sv */
`default_nettype none

package vision_pkg;

    typedef logic [9:0]  coord_t;
    // RGB565, 4-bit fields taken at 15..12, 10..7 and 4..1
    typedef logic [15:0] pixel_t;
    typedef logic [9:0]  speed_t;
    typedef logic [1:0]  event_kind_t;
    // record layout is {kind, payload, frame}
    typedef logic [19:0] event_rec_t;
    typedef logic [7:0]  frame_t;
    typedef logic [3:0]  log_addr_t;
    typedef logic [4:0]  log_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        DETECT,
        TRACK,
        CALC,
        WAIT_RELEASE
    } det_state_t;

    localparam event_kind_t KIND_COLLISION = 2'd1;
    localparam event_kind_t KIND_MISS      = 2'd2;

    localparam int COLLISION_THRESHOLD = 19;
    localparam int TRACK_DURATION      = 10;

    localparam int     SCREEN_W     = 640;
    localparam int     BALL_SIZE    = 8;
    localparam coord_t BALL_START_X = 10'd320;
    localparam coord_t BALL_START_Y = 10'd240;
    localparam speed_t INIT_SPEED   = 10'd2;

    localparam int LOG_DEPTH = 16;

    // red bands, dark and bright
    localparam logic [3:0] DARK_R_MIN    = 4'd10;
    localparam logic [3:0] DARK_R_MAX    = 4'd12;
    localparam logic [3:0] DARK_GB_MAX   = 4'd3;
    localparam logic [3:0] BRIGHT_R_MIN  = 4'd13;
    localparam logic [3:0] BRIGHT_GB_MAX = 4'd5;

endpackage

`default_nettype wire

/* color/color_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module color_detector (
    input  wire                 clk_25MHz,
    input  wire                 reset,
    input  wire vision_pkg::pixel_t camera_pixel,
    input  wire vision_pkg::coord_t x_pixel,
    input  wire vision_pkg::coord_t y_pixel,
    output vision_pkg::coord_t  px_x,
    output vision_pkg::coord_t  px_y,
    output logic                is_target_color
);

    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic       dark_red;
    logic       bright_red;

    assign r = camera_pixel[15:12];
    assign g = camera_pixel[10:7];
    assign b = camera_pixel[4:1];

    assign dark_red = (r >= vision_pkg::DARK_R_MIN) && (r <= vision_pkg::DARK_R_MAX) &&
                      (g <= vision_pkg::DARK_GB_MAX) && (b <= vision_pkg::DARK_GB_MAX);
    assign bright_red = (r >= vision_pkg::BRIGHT_R_MIN) &&
                        (g <= vision_pkg::BRIGHT_GB_MAX) && (b <= vision_pkg::BRIGHT_GB_MAX);

    // flag and coordinates stay aligned for the later stages
    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            px_x            <= '0;
            px_y            <= '0;
            is_target_color <= 1'b0;
        end else begin
            px_x            <= x_pixel;
            px_y            <= y_pixel;
            is_target_color <= dark_red || bright_red;
        end
    end

endmodule

`default_nettype wire

/* collision/collision_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module collision_detector (
    input  wire                 clk_25MHz,
    input  wire                 reset,
    input  wire vision_pkg::coord_t px_x,
    input  wire                 is_hit_area,
    input  wire                 is_target_color,
    input  wire                 is_ball_moving_left,
    output logic                collision_detected,
    output logic                coll_event,
    output vision_pkg::speed_t  estimated_speed
);

    vision_pkg::det_state_t state;
    vision_pkg::det_state_t state_next;

    // detection run
    logic [15:0]        det_sum;
    logic [15:0]        det_sum_next;
    logic [4:0]         det_cnt;
    logic [4:0]         det_cnt_next;
    vision_pkg::coord_t prev_center;
    vision_pkg::coord_t prev_center_next;

    // tracking run
    logic [15:0]        trk_sum;
    logic [15:0]        trk_sum_next;
    logic [3:0]         trk_cnt;
    logic [3:0]         trk_cnt_next;
    vision_pkg::coord_t curr_center;
    vision_pkg::coord_t curr_center_next;

    vision_pkg::speed_t speed_next;
    logic               coll_event_next;
    logic               qualify;
    vision_pkg::coord_t center_diff;

    assign qualify = is_hit_area && is_target_color;

    assign center_diff = (curr_center > prev_center) ? curr_center - prev_center
                                                     : prev_center - curr_center;

    assign collision_detected = (state == vision_pkg::TRACK) || (state == vision_pkg::CALC);

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            state           <= vision_pkg::IDLE;
            det_sum         <= '0;
            det_cnt         <= '0;
            prev_center     <= '0;
            trk_sum         <= '0;
            trk_cnt         <= '0;
            curr_center     <= '0;
            estimated_speed <= '0;
            coll_event      <= 1'b0;
        end else begin
            state           <= state_next;
            det_sum         <= det_sum_next;
            det_cnt         <= det_cnt_next;
            prev_center     <= prev_center_next;
            trk_sum         <= trk_sum_next;
            trk_cnt         <= trk_cnt_next;
            curr_center     <= curr_center_next;
            estimated_speed <= speed_next;
            coll_event      <= coll_event_next;
        end
    end

    always_comb begin
        state_next       = state;
        det_sum_next     = det_sum;
        det_cnt_next     = det_cnt;
        prev_center_next = prev_center;
        trk_sum_next     = trk_sum;
        trk_cnt_next     = trk_cnt;
        curr_center_next = curr_center;
        speed_next       = estimated_speed;
        coll_event_next  = 1'b0;

        case (state)
            vision_pkg::IDLE: begin
                if (qualify) begin
                    det_sum_next = {6'd0, px_x};
                    det_cnt_next = 5'd1;
                    state_next   = vision_pkg::DETECT;
                end
            end

            vision_pkg::DETECT: begin
                if (qualify) begin
                    det_sum_next = det_sum + {6'd0, px_x};
                    det_cnt_next = det_cnt + 5'd1;
                    // this pixel is the 20th of the run
                    if (det_cnt == 5'(vision_pkg::COLLISION_THRESHOLD)) begin
                        prev_center_next = vision_pkg::coord_t'(
                            det_sum_next / 16'(vision_pkg::COLLISION_THRESHOLD + 1));
                        trk_sum_next = '0;
                        trk_cnt_next = '0;
                        state_next   = vision_pkg::TRACK;
                    end
                end else begin
                    state_next = vision_pkg::IDLE;
                end
            end

            vision_pkg::TRACK: begin
                if (qualify) begin
                    trk_sum_next = trk_sum + {6'd0, px_x};
                    trk_cnt_next = trk_cnt + 4'd1;
                    if (trk_cnt == 4'(vision_pkg::TRACK_DURATION)) begin
                        curr_center_next = vision_pkg::coord_t'(
                            trk_sum_next / 16'(vision_pkg::TRACK_DURATION + 1));
                        state_next = vision_pkg::CALC;
                    end
                end else begin
                    state_next = vision_pkg::IDLE;
                end
            end

            vision_pkg::CALC: begin
                // a still paddle still returns the ball
                if (center_diff == '0) begin
                    speed_next = vision_pkg::speed_t'(1);
                end else begin
                    speed_next = vision_pkg::speed_t'(center_diff);
                end
                // one bounce per contact
                coll_event_next = is_ball_moving_left;
                state_next      = vision_pkg::WAIT_RELEASE;
            end

            vision_pkg::WAIT_RELEASE: begin
                if (!qualify) begin
                    state_next = vision_pkg::IDLE;
                end
            end

            default: begin
                state_next = vision_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/ball_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module ball_tracker (
    input  wire                 clk_25MHz,
    input  wire                 reset,
    input  wire                 frame_start,
    input  wire vision_pkg::coord_t px_x,
    input  wire vision_pkg::coord_t px_y,
    input  wire                 coll_event,
    input  wire vision_pkg::speed_t estimated_speed,
    output logic                is_hit_area,
    output logic                is_ball_moving_left,
    output logic                miss_event,
    output vision_pkg::coord_t  ball_x,
    output vision_pkg::coord_t  ball_y,
    output vision_pkg::coord_t  miss_y
);

    vision_pkg::speed_t speed;
    logic [10:0]        right_pos;
    logic               right_clamp;
    logic               miss_now;
    logic               hit_x;
    logic               hit_y;

    assign right_pos   = {1'b0, ball_x} + {1'b0, speed};
    assign right_clamp = right_pos > 11'(vision_pkg::SCREEN_W - vision_pkg::BALL_SIZE);

    // leaving past the left edge
    assign miss_now = frame_start && is_ball_moving_left && (speed > ball_x);

    assign hit_x = (px_x >= ball_x) &&
                   ({1'b0, px_x} < {1'b0, ball_x} + 11'(vision_pkg::BALL_SIZE));
    assign hit_y = (px_y >= ball_y) &&
                   ({1'b0, px_y} < {1'b0, ball_y} + 11'(vision_pkg::BALL_SIZE));
    assign is_hit_area = hit_x && hit_y;

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            ball_x              <= vision_pkg::BALL_START_X;
            ball_y              <= vision_pkg::BALL_START_Y;
            speed               <= vision_pkg::INIT_SPEED;
            is_ball_moving_left <= 1'b1;
            miss_event          <= 1'b0;
        end else begin
            miss_event <= miss_now;

            if (frame_start) begin
                if (!is_ball_moving_left) begin
                    if (right_clamp) begin
                        ball_x              <= vision_pkg::coord_t'(
                            vision_pkg::SCREEN_W - vision_pkg::BALL_SIZE);
                        is_ball_moving_left <= 1'b1;
                    end else begin
                        ball_x <= right_pos[9:0];
                    end
                end else if (miss_now) begin
                    ball_x <= vision_pkg::BALL_START_X;
                    ball_y <= vision_pkg::BALL_START_Y;
                    speed  <= vision_pkg::INIT_SPEED;
                end else begin
                    ball_x <= ball_x - speed;
                end
            end

            // paddle hit turns the ball right at the measured speed
            if (coll_event) begin
                is_ball_moving_left <= 1'b0;
                speed               <= estimated_speed;
            end
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (miss_now) begin
            miss_y <= ball_y;
        end
    end

endmodule

`default_nettype wire

/* logic/event_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module event_arbiter (
    input  wire                 clk_25MHz,
    input  wire                 reset,
    input  wire                 frame_start,
    input  wire                 coll_event,
    input  wire vision_pkg::speed_t estimated_speed,
    input  wire                 miss_event,
    input  wire vision_pkg::coord_t miss_y,
    output logic                log_we,
    output vision_pkg::event_rec_t log_wdata
);

    vision_pkg::frame_t frame_cnt;
    vision_pkg::coord_t pending_y;
    logic               miss_pending;
    logic               write_coll;
    logic               write_miss;

    // collision always wins, a miss waits for a free cycle
    assign write_coll = coll_event;
    assign write_miss = !coll_event && (miss_pending || miss_event);

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            frame_cnt    <= '0;
            miss_pending <= 1'b0;
            log_we       <= 1'b0;
        end else begin
            if (frame_start) begin
                frame_cnt <= frame_cnt + 8'd1;
            end
            log_we <= write_coll || write_miss;
            if (write_miss) begin
                miss_pending <= 1'b0;
            end else if (miss_event) begin
                miss_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (miss_event) begin
            pending_y <= miss_y;
        end
        if (write_coll) begin
            log_wdata <= {vision_pkg::KIND_COLLISION, estimated_speed, frame_cnt};
        end else if (write_miss) begin
            log_wdata <= {vision_pkg::KIND_MISS, miss_pending ? pending_y : miss_y, frame_cnt};
        end
    end

endmodule

`default_nettype wire

/* logic/event_log.sv */
`timescale 1ns/100ps
`default_nettype none

module event_log (
    input  wire                     clk_25MHz,
    input  wire                     reset,
    input  wire                     log_we,
    input  wire vision_pkg::event_rec_t log_wdata,
    input  wire vision_pkg::log_addr_t  log_rd_addr,
    output vision_pkg::event_rec_t  log_rd_data,
    output vision_pkg::log_cnt_t    log_count
);

    vision_pkg::event_rec_t mem [vision_pkg::LOG_DEPTH];
    logic                   log_full;
    logic                   do_write;

    assign log_full = (log_count == vision_pkg::log_cnt_t'(vision_pkg::LOG_DEPTH));
    // once full, later records are dropped
    assign do_write = log_we && !log_full;

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            log_count <= '0;
        end else if (do_write) begin
            log_count <= log_count + 5'd1;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (do_write) begin
            mem[vision_pkg::log_addr_t'(log_count[3:0])] <= log_wdata;
        end
        // host read, one cycle latency
        log_rd_data <= mem[log_rd_addr];
    end

endmodule

`default_nettype wire

/* logic/pong_vision_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pong_vision_top (
    input  wire                     clk_25MHz,
    input  wire                     reset,
    input  wire vision_pkg::pixel_t     camera_pixel,
    input  wire vision_pkg::coord_t     x_pixel,
    input  wire vision_pkg::coord_t     y_pixel,
    input  wire                     frame_start,
    input  wire vision_pkg::log_addr_t  log_rd_addr,
    output logic                    collision_detected,
    output vision_pkg::speed_t      estimated_speed,
    output vision_pkg::coord_t      ball_x,
    output vision_pkg::coord_t      ball_y,
    output vision_pkg::log_cnt_t    log_count,
    output vision_pkg::event_rec_t  log_rd_data
);

    vision_pkg::coord_t     px_x;
    vision_pkg::coord_t     px_y;
    logic                   is_target_color;
    logic                   is_hit_area;
    logic                   is_ball_moving_left;
    logic                   coll_event;
    logic                   miss_event;
    vision_pkg::coord_t     miss_y;
    logic                   log_we;
    vision_pkg::event_rec_t log_wdata;

    color_detector color_detector_i (
        .clk_25MHz       (clk_25MHz),
        .reset           (reset),
        .camera_pixel    (camera_pixel),
        .x_pixel         (x_pixel),
        .y_pixel         (y_pixel),
        .px_x            (px_x),
        .px_y            (px_y),
        .is_target_color (is_target_color)
    );

    collision_detector collision_detector_i (
        .clk_25MHz           (clk_25MHz),
        .reset               (reset),
        .px_x                (px_x),
        .is_hit_area         (is_hit_area),
        .is_target_color     (is_target_color),
        .is_ball_moving_left (is_ball_moving_left),
        .collision_detected  (collision_detected),
        .coll_event          (coll_event),
        .estimated_speed     (estimated_speed)
    );

    ball_tracker ball_tracker_i (
        .clk_25MHz           (clk_25MHz),
        .reset               (reset),
        .frame_start         (frame_start),
        .px_x                (px_x),
        .px_y                (px_y),
        .coll_event          (coll_event),
        .estimated_speed     (estimated_speed),
        .is_hit_area         (is_hit_area),
        .is_ball_moving_left (is_ball_moving_left),
        .miss_event          (miss_event),
        .ball_x              (ball_x),
        .ball_y              (ball_y),
        .miss_y              (miss_y)
    );

    // both event sources share the one log
    event_arbiter event_arbiter_i (
        .clk_25MHz       (clk_25MHz),
        .reset           (reset),
        .frame_start     (frame_start),
        .coll_event      (coll_event),
        .estimated_speed (estimated_speed),
        .miss_event      (miss_event),
        .miss_y          (miss_y),
        .log_we          (log_we),
        .log_wdata       (log_wdata)
    );

    event_log event_log_i (
        .clk_25MHz   (clk_25MHz),
        .reset       (reset),
        .log_we      (log_we),
        .log_wdata   (log_wdata),
        .log_rd_addr (log_rd_addr),
        .log_rd_data (log_rd_data),
        .log_count   (log_count)
    );

endmodule

`default_nettype wire

/* verif/tb_pong_vision.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pong_vision;

    // about 1500 cycles of tests plus margin
    localparam int CYCLE_LIMIT = 2000;

    logic                   clk_25MHz;
    logic                   reset;
    vision_pkg::pixel_t     camera_pixel;
    vision_pkg::coord_t     x_pixel;
    vision_pkg::coord_t     y_pixel;
    logic                   frame_start;
    vision_pkg::log_addr_t  log_rd_addr;
    logic                   collision_detected;
    vision_pkg::speed_t     estimated_speed;
    vision_pkg::coord_t     ball_x;
    vision_pkg::coord_t     ball_y;
    vision_pkg::log_cnt_t   log_count;
    vision_pkg::event_rec_t log_rd_data;

    logic [15:0]            lfsr_state;
    int                     cycle_count;
    string                  test_name;
    logic                   coll_seen;

    // reference ball and log
    vision_pkg::coord_t     model_x;
    vision_pkg::coord_t     model_y;
    vision_pkg::speed_t     model_speed;
    logic                   model_left;
    vision_pkg::frame_t     model_frame;
    vision_pkg::event_rec_t exp_log[$];

    pong_vision_top dut_i (
        .clk_25MHz          (clk_25MHz),
        .reset              (reset),
        .camera_pixel       (camera_pixel),
        .x_pixel            (x_pixel),
        .y_pixel            (y_pixel),
        .frame_start        (frame_start),
        .log_rd_addr        (log_rd_addr),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .log_count          (log_count),
        .log_rd_data        (log_rd_data)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    task automatic abort_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk_25MHz) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("timeout, the tests ran past the cycle limit");
        end
    end

    task automatic compare_coord(input vision_pkg::coord_t expected,
                                 input vision_pkg::coord_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
            abort_run("coordinate mismatch");
        end
    endtask

    task automatic compare_speed(input vision_pkg::speed_t expected,
                                 input vision_pkg::speed_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
            abort_run("speed mismatch");
        end
    endtask

    task automatic compare_count(input vision_pkg::log_cnt_t expected,
                                 input vision_pkg::log_cnt_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
            abort_run("log count mismatch");
        end
    endtask

    task automatic compare_rec(input vision_pkg::event_rec_t expected,
                               input vision_pkg::event_rec_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            abort_run("log record mismatch");
        end
    endtask

    task automatic compare_bit(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", test_name, expected, actual);
            abort_run("flag mismatch");
        end
    endtask

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [15:0] random_word(input int nbits);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic is_red(input vision_pkg::pixel_t p);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = p[15:12];
        g = p[10:7];
        b = p[4:1];
        return ((r >= 4'd10) && (r <= 4'd12) && (g <= 4'd3) && (b <= 4'd3)) ||
               ((r >= 4'd13) && (g <= 4'd5) && (b <= 4'd5));
    endfunction

    task automatic random_pixel(input logic want_red, output vision_pkg::pixel_t p);
        p = random_word(16);
        while (is_red(p) != want_red) begin
            p = random_word(16);
        end
    endtask

    task automatic drive_pixel(input vision_pkg::coord_t x, input vision_pkg::coord_t y,
                               input logic red);
        vision_pkg::pixel_t p;
        random_pixel(red, p);
        @(negedge clk_25MHz);
        coll_seen    = coll_seen | collision_detected;
        camera_pixel = p;
        x_pixel      = x;
        y_pixel      = y;
        frame_start  = 1'b0;
    endtask

    // one scan line on a non-red background with a red span
    task automatic scan_line(input vision_pkg::coord_t y, input vision_pkg::coord_t x0,
                             input int len, input int red_from, input int red_to);
        for (int i = 0; i < len; i++) begin
            drive_pixel(vision_pkg::coord_t'(int'(x0) + i), y, (i >= red_from) && (i < red_to));
        end
    endtask

    // red pixels inside the ball box, x wrapping over span columns
    task automatic paddle_run(input int off, input int span, input int len, output int sum);
        vision_pkg::coord_t x;
        sum = 0;
        for (int i = 0; i < len; i++) begin
            x = vision_pkg::coord_t'(int'(model_x) + off + (i % span));
            sum = sum + int'(x);
            drive_pixel(x, model_y + 10'd3, 1'b1);
        end
    endtask

    task automatic release_paddle(input int len);
        repeat (len) drive_pixel(model_x, model_y + 10'd3, 1'b0);
    endtask

    task automatic hit_paddle(input int off1, input int span1, input int off2,
                              input int span2, output vision_pkg::speed_t exp_speed);
        int sum1;
        int sum2;
        int diff;
        coll_seen = 1'b0;
        paddle_run(off1, span1, 20, sum1);
        paddle_run(off2, span2, 11, sum2);
        diff = (sum1 / 20) - (sum2 / 11);
        if (diff < 0) begin
            diff = -diff;
        end
        exp_speed = (diff == 0) ? 10'd1 : vision_pkg::speed_t'(diff);
    endtask

    task automatic step_ball_model();
        model_frame = model_frame + 8'd1;
        if (!model_left) begin
            if (int'(model_x) + int'(model_speed) >
                vision_pkg::SCREEN_W - vision_pkg::BALL_SIZE) begin
                model_x    = vision_pkg::coord_t'(vision_pkg::SCREEN_W - vision_pkg::BALL_SIZE);
                model_left = 1'b1;
            end else begin
                model_x = model_x + model_speed;
            end
        end else if (model_speed > model_x) begin
            exp_log.push_back({vision_pkg::KIND_MISS, model_y, model_frame});
            model_x     = 10'd320;
            model_y     = 10'd240;
            model_speed = 10'd2;
        end else begin
            model_x = model_x - model_speed;
        end
    endtask

    task automatic pulse_frame();
        vision_pkg::pixel_t p;
        random_pixel(1'b0, p);
        @(negedge clk_25MHz);
        camera_pixel = p;
        x_pixel      = '0;
        y_pixel      = '0;
        frame_start  = 1'b1;
        step_ball_model();
        @(negedge clk_25MHz);
        frame_start = 1'b0;
        compare_coord(model_x, ball_x);
        compare_coord(model_y, ball_y);
    endtask

    task automatic wait_log_count();
        vision_pkg::log_cnt_t expected;
        int n;
        expected = (exp_log.size() > 16) ? 5'd16 : vision_pkg::log_cnt_t'(exp_log.size());
        n = 0;
        while (log_count !== expected) begin
            if (n >= 20) begin
                abort_run("the log never reached the expected number of records");
            end else begin
                @(negedge clk_25MHz);
                n++;
            end
        end
    endtask

    task automatic read_log(input vision_pkg::log_addr_t a, output vision_pkg::event_rec_t r);
        @(negedge clk_25MHz);
        log_rd_addr = a;
        @(negedge clk_25MHz);
        r = log_rd_data;
    endtask

    task automatic check_log(input int n);
        vision_pkg::event_rec_t r;
        for (int i = 0; i < n; i++) begin
            read_log(vision_pkg::log_addr_t'(i), r);
            compare_rec(exp_log[i], r);
        end
    endtask

    // full paddle contact with a left-moving ball
    task automatic collide(input int off1, input int span1, input int off2, input int span2);
        vision_pkg::speed_t exp_speed;
        hit_paddle(off1, span1, off2, span2, exp_speed);
        // speed and bounce settle in the tracker
        release_paddle(4);
        exp_log.push_back({vision_pkg::KIND_COLLISION, exp_speed, model_frame});
        model_left  = 1'b0;
        model_speed = exp_speed;
        wait_log_count();
        compare_speed(exp_speed, estimated_speed);
        compare_bit(1'b1, coll_seen);
    endtask

    task automatic apply_reset();
        @(negedge clk_25MHz);
        reset        = 1'b1;
        camera_pixel = '0;
        x_pixel      = '0;
        y_pixel      = '0;
        frame_start  = 1'b0;
        log_rd_addr  = '0;
        repeat (3) @(negedge clk_25MHz);
        reset       = 1'b0;
        model_x     = 10'd320;
        model_y     = 10'd240;
        model_speed = 10'd2;
        model_left  = 1'b1;
        model_frame = '0;
        exp_log.delete();
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        apply_reset();
        compare_coord(10'd320, ball_x);
        compare_coord(10'd240, ball_y);
        compare_count(5'd0, log_count);
        compare_bit(1'b0, collision_detected);
        coll_seen = 1'b0;
        scan_line(10'd243, 10'd310, 30, 0, 0);
        scan_line(10'd100, 10'd310, 30, 0, 30);
        scan_line(10'd243, 10'd330, 30, 0, 30);
        // long non-red run held inside the ball box
        release_paddle(40);
        compare_bit(1'b0, coll_seen);
        compare_count(5'd0, log_count);
    endtask

    task automatic test_ball_motion();
        test_name = "ball_motion";
        apply_reset();
        repeat (5) pulse_frame();
        compare_coord(10'd310, ball_x);
    endtask

    task automatic test_collision_speed();
        test_name = "collision_speed";
        apply_reset();
        repeat (2) pulse_frame();
        collide(0, 4, 4, 4);
        check_log(1);
        pulse_frame();
    endtask

    task automatic test_broken_run();
        int sum;
        test_name = "broken_run";
        apply_reset();
        collide(0, 1, 7, 1);
        // back off the right edge so the broken runs meet a left-moving ball
        while (!model_left) begin
            pulse_frame();
        end
        coll_seen = 1'b0;
        paddle_run(0, 8, 12, sum);
        release_paddle(1);
        paddle_run(5, 3, 19, sum);
        release_paddle(6);
        compare_bit(1'b0, coll_seen);
        compare_count(5'd1, log_count);
        compare_speed(model_speed, estimated_speed);
    endtask

    // contact lands on the same cycle as the miss
    task automatic test_miss_order();
        vision_pkg::speed_t exp_speed;
        test_name = "miss_order";
        apply_reset();
        while (model_speed <= model_x) begin
            pulse_frame();
        end
        hit_paddle(0, 1, 7, 1, exp_speed);
        release_paddle(1);
        exp_log.push_back({vision_pkg::KIND_COLLISION, exp_speed, model_frame + 8'd1});
        pulse_frame();
        model_left  = 1'b0;
        model_speed = exp_speed;
        compare_bit(1'b1, coll_seen);
        wait_log_count();
        check_log(2);
    endtask

    task automatic test_log_full();
        int off1;
        int off2;
        test_name = "log_full";
        apply_reset();
        collide(0, 1, 7, 1);
        while (!model_left) begin
            pulse_frame();
        end
        for (int k = 0; k < 16; k++) begin
            off1 = int'(random_word(3));
            off2 = (k == 0) ? off1 : int'(random_word(3));
            collide(off1, 1, off2, 1);
            pulse_frame();
        end
        repeat (4) @(negedge clk_25MHz);
        compare_count(5'd16, log_count);
        check_log(16);
    endtask

    initial begin
        reset        = 1'b1;
        camera_pixel = '0;
        x_pixel      = '0;
        y_pixel      = '0;
        frame_start  = 1'b0;
        log_rd_addr  = '0;
        lfsr_state   = 16'd98;
        cycle_count  = 0;
        coll_seen    = 1'b0;
        test_reset_state();
        test_ball_motion();
        test_collision_speed();
        test_broken_run();
        test_miss_order();
        test_log_full();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/vision_pkg.sv
color/color_detector.sv
collision/collision_detector.sv
logic/ball_tracker.sv
logic/event_arbiter.sv
logic/event_log.sv
logic/pong_vision_top.sv
verif/tb_pong_vision.sv
